//--- hw/rv32_isa_pkg.sv
package rv32_isa_pkg;

    // major opcodes, instr[6:0]
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op     = 7'b0110011;

    localparam logic [2:0] funct3_jalr = 3'b000;

    // branch conditions
    localparam logic [2:0] funct3_beq  = 3'b000;
    localparam logic [2:0] funct3_bne  = 3'b001;
    localparam logic [2:0] funct3_blt  = 3'b100;
    localparam logic [2:0] funct3_bge  = 3'b101;
    localparam logic [2:0] funct3_bltu = 3'b110;
    localparam logic [2:0] funct3_bgeu = 3'b111;

    // load and store widths
    localparam logic [2:0] funct3_lb  = 3'b000;
    localparam logic [2:0] funct3_lh  = 3'b001;
    localparam logic [2:0] funct3_lw  = 3'b010;
    localparam logic [2:0] funct3_lbu = 3'b100;
    localparam logic [2:0] funct3_lhu = 3'b101;
    localparam logic [2:0] funct3_sb  = 3'b000;
    localparam logic [2:0] funct3_sh  = 3'b001;
    localparam logic [2:0] funct3_sw  = 3'b010;

    // ALU functions, shared by OP and OP-IMM
    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_sll     = 3'b001;
    localparam logic [2:0] funct3_slt     = 3'b010;
    localparam logic [2:0] funct3_sltu    = 3'b011;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_srl_sra = 3'b101;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;

    localparam logic [6:0] funct7_zero = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000; // selects SUB and SRA

endpackage

//--- hw/rv32_ctrl_pkg.sv
package rv32_ctrl_pkg;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b // operand b unchanged, used by LUI
    } alu_op_e;

    typedef enum logic {
        src_a_rs1,
        src_a_pc
    } src_a_e;

    typedef enum logic {
        src_b_rs2,
        src_b_imm
    } src_b_e;

    // what the execute stage retires and whether rd gets written
    typedef enum logic [2:0] {
        kind_alu,
        kind_link,
        kind_mem_addr,
        kind_branch
    } kind_e;

endpackage

//--- hw/rv32_decode.sv
module rv32_decode #(
    parameter int reg_count = 32
) (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      instr_valid_i,
    input  logic [31:0]               instr_i,
    input  logic [31:0]               pc_i,
    input  logic [31:0]               rs1_value_i,
    input  logic [31:0]               rs2_value_i,
    output rv32_ctrl_pkg::reg_addr_t  rs1_addr_o,
    output rv32_ctrl_pkg::reg_addr_t  rs2_addr_o,
    output logic                      illegal_o,
    output logic                      dec_valid_o,
    output logic [31:0]               dec_pc_o,
    output rv32_ctrl_pkg::reg_addr_t  dec_rs1_addr_o,
    output logic [31:0]               dec_rs1_value_o,
    output rv32_ctrl_pkg::reg_addr_t  dec_rs2_addr_o,
    output logic [31:0]               dec_rs2_value_o,
    output logic [31:0]               dec_imm_o,
    output rv32_ctrl_pkg::reg_addr_t  dec_rd_o,
    output logic [2:0]                dec_funct3_o,
    output rv32_ctrl_pkg::alu_op_e    dec_alu_op_o,
    output rv32_ctrl_pkg::src_a_e     dec_src_a_o,
    output rv32_ctrl_pkg::src_b_e     dec_src_b_o,
    output rv32_ctrl_pkg::kind_e      dec_kind_o
);
    import rv32_isa_pkg::*;
    import rv32_ctrl_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] shamt;

    logic        match;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        uses_rd;
    logic        bad_reg;
    logic        legal;
    logic [31:0] imm;
    alu_op_e     alu_op;
    src_a_e      src_a;
    src_b_e      src_b;
    kind_e       kind;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign rd     = instr_i[11:7];

    assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign shamt = {27'b0, instr_i[24:20]};

    // the register file is read straight from the instruction bits
    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    function automatic alu_op_e alu_op_for(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            funct3_add_sub: op = alt ? alu_sub : alu_add;
            funct3_sll:     op = alu_sll;
            funct3_slt:     op = alu_slt;
            funct3_sltu:    op = alu_sltu;
            funct3_xor:     op = alu_xor;
            funct3_srl_sra: op = alt ? alu_sra : alu_srl;
            funct3_or:      op = alu_or;
            funct3_and:     op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        match    = 1'b0;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        uses_rd  = 1'b1;
        imm      = imm_i;
        alu_op   = alu_add;
        src_a    = src_a_rs1;
        src_b    = src_b_imm;
        kind     = kind_alu;
        case (opcode)
            opcode_lui: begin
                match    = 1'b1;
                uses_rs1 = 1'b0;
                imm      = imm_u;
                alu_op   = alu_pass_b;
            end
            opcode_auipc: begin
                match    = 1'b1;
                uses_rs1 = 1'b0;
                imm      = imm_u;
                src_a    = src_a_pc;
            end
            opcode_jal: begin
                match    = 1'b1;
                uses_rs1 = 1'b0;
                imm      = imm_j;
                kind     = kind_link;
            end
            opcode_jalr: begin
                match = funct3 == funct3_jalr;
                kind  = kind_link;
            end
            opcode_branch: begin
                match    = funct3 inside {funct3_beq, funct3_bne, funct3_blt, funct3_bge,
                                          funct3_bltu, funct3_bgeu};
                uses_rs2 = 1'b1;
                uses_rd  = 1'b0;
                imm      = imm_b;
                kind     = kind_branch;
            end
            opcode_load: begin
                match = funct3 inside {funct3_lb, funct3_lh, funct3_lw, funct3_lbu, funct3_lhu};
                kind  = kind_mem_addr; // no data memory, only the address retires
            end
            opcode_store: begin
                match    = funct3 inside {funct3_sb, funct3_sh, funct3_sw};
                uses_rs2 = 1'b1;
                uses_rd  = 1'b0;
                imm      = imm_s;
                kind     = kind_mem_addr;
            end
            opcode_op_imm: begin
                // instr[30] is an immediate bit except on the right shifts
                alu_op = alu_op_for(funct3, funct3 == funct3_srl_sra && funct7 == funct7_alt);
                if (funct3 == funct3_sll) begin
                    match = funct7 == funct7_zero;
                    imm   = shamt;
                end else if (funct3 == funct3_srl_sra) begin
                    match = funct7 == funct7_zero || funct7 == funct7_alt;
                    imm   = shamt;
                end else begin
                    match = 1'b1;
                end
            end
            opcode_op: begin
                match    = funct7 == funct7_zero ||
                           (funct7 == funct7_alt &&
                            (funct3 == funct3_add_sub || funct3 == funct3_srl_sra));
                uses_rs2 = 1'b1;
                src_b    = src_b_rs2;
                alu_op   = alu_op_for(funct3, funct7 == funct7_alt);
            end
            default: match = 1'b0;
        endcase
    end

    // only the fields an encoding really uses count against a reduced register file
    assign bad_reg = (uses_rs1 && rs1 >= reg_count) ||
                     (uses_rs2 && rs2 >= reg_count) ||
                     (uses_rd && rd >= reg_count);
    assign legal   = match && !bad_reg;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
            illegal_o   <= 1'b0;
        end else begin
            dec_valid_o <= instr_valid_i && legal;
            illegal_o   <= instr_valid_i && !legal;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            dec_pc_o        <= pc_i;
            dec_rs1_addr_o  <= rs1;
            dec_rs1_value_o <= rs1_value_i;
            dec_rs2_addr_o  <= rs2;
            dec_rs2_value_o <= rs2_value_i;
            dec_imm_o       <= imm;
            dec_rd_o        <= rd;
            dec_funct3_o    <= funct3;
            dec_alu_op_o    <= alu_op;
            dec_src_a_o     <= src_a;
            dec_src_b_o     <= src_b;
            dec_kind_o      <= kind;
        end
    end

    a_valid_or_illegal: assert property (
        @(posedge clk) disable iff (reset_i) !(dec_valid_o && illegal_o)
    );

endmodule

//--- hw/rv32_regs.sv
module rv32_regs #(
    parameter int reg_count = 32
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  rv32_ctrl_pkg::reg_addr_t rs1_addr_i,
    input  rv32_ctrl_pkg::reg_addr_t rs2_addr_i,
    input  logic                     wb_en_i,
    input  rv32_ctrl_pkg::reg_addr_t wb_addr_i,
    input  logic [31:0]              wb_value_i,
    output logic [31:0]              rs1_value_o,
    output logic [31:0]              rs2_value_o
);
    logic [31:0] regs [1:reg_count-1]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && wb_addr_i != '0 && wb_addr_i < reg_count) begin
            regs[wb_addr_i] <= wb_value_i;
        end
    end

    // x0 and indices past the file read as zero
    assign rs1_value_o = (rs1_addr_i == '0 || rs1_addr_i >= reg_count) ? '0 : regs[rs1_addr_i];
    assign rs2_value_o = (rs2_addr_i == '0 || rs2_addr_i >= reg_count) ? '0 : regs[rs2_addr_i];

    a_wb_in_range: assert property (
        @(posedge clk) disable iff (reset_i) wb_en_i |-> wb_addr_i < reg_count
    );

endmodule

//--- hw/rv32_execute.sv
module rv32_execute (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     dec_valid_i,
    input  logic [31:0]              dec_pc_i,
    input  rv32_ctrl_pkg::reg_addr_t dec_rs1_addr_i,
    input  logic [31:0]              dec_rs1_value_i,
    input  rv32_ctrl_pkg::reg_addr_t dec_rs2_addr_i,
    input  logic [31:0]              dec_rs2_value_i,
    input  logic [31:0]              dec_imm_i,
    input  rv32_ctrl_pkg::reg_addr_t dec_rd_i,
    input  logic [2:0]               dec_funct3_i,
    input  rv32_ctrl_pkg::alu_op_e   dec_alu_op_i,
    input  rv32_ctrl_pkg::src_a_e    dec_src_a_i,
    input  rv32_ctrl_pkg::src_b_e    dec_src_b_i,
    input  rv32_ctrl_pkg::kind_e     dec_kind_i,
    output logic                     wb_en_o,
    output rv32_ctrl_pkg::reg_addr_t wb_addr_o,
    output logic [31:0]              wb_value_o,
    output logic                     retire_valid_o,
    output logic [31:0]              retire_pc_o,
    output rv32_ctrl_pkg::reg_addr_t retire_rd_o,
    output logic                     retire_we_o,
    output logic [31:0]              retire_value_o,
    output logic                     branch_taken_o
);
    import rv32_isa_pkg::*;
    import rv32_ctrl_pkg::*;

    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic [31:0] link_value;
    logic [31:0] retire_value;
    logic        taken;
    logic        write_rd;

    // the previous instruction writes the register file at the edge this one was read,
    // so its value is taken from the retire register instead
    assign rs1_value = (retire_we_o && retire_rd_o == dec_rs1_addr_i) ? retire_value_o
                                                                       : dec_rs1_value_i;
    assign rs2_value = (retire_we_o && retire_rd_o == dec_rs2_addr_i) ? retire_value_o
                                                                       : dec_rs2_value_i;

    assign op_a = (dec_src_a_i == src_a_pc) ? dec_pc_i : rs1_value;
    assign op_b = (dec_src_b_i == src_b_imm) ? dec_imm_i : rs2_value;

    always_comb begin
        case (dec_alu_op_i)
            alu_add:  alu_result = op_a + op_b;
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << op_b[4:0];
            alu_slt:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_result = {31'b0, op_a < op_b};
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> op_b[4:0];
            alu_sra:  alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = op_b;
        endcase
    end

    always_comb begin
        case (dec_funct3_i)
            funct3_beq:  taken = rs1_value == rs2_value;
            funct3_bne:  taken = rs1_value != rs2_value;
            funct3_blt:  taken = $signed(rs1_value) < $signed(rs2_value);
            funct3_bge:  taken = $signed(rs1_value) >= $signed(rs2_value);
            funct3_bltu: taken = rs1_value < rs2_value;
            funct3_bgeu: taken = rs1_value >= rs2_value;
            default:     taken = 1'b0;
        endcase
    end

    assign link_value = dec_pc_i + 32'd4;

    always_comb begin
        case (dec_kind_i)
            kind_link:     retire_value = link_value;
            kind_mem_addr: retire_value = rs1_value + dec_imm_i;
            kind_branch:   retire_value = dec_pc_i + dec_imm_i; // branch target
            default:       retire_value = alu_result;
        endcase
    end

    assign write_rd = (dec_kind_i == kind_alu || dec_kind_i == kind_link) && dec_rd_i != '0;

    // writeback lands at the same edge that loads the retire register
    assign wb_en_o    = dec_valid_i && write_rd;
    assign wb_addr_o  = dec_rd_i;
    assign wb_value_o = retire_value;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            retire_valid_o <= 1'b0;
            retire_we_o    <= 1'b0;
        end else begin
            retire_valid_o <= dec_valid_i;
            retire_we_o    <= dec_valid_i && write_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            retire_pc_o    <= dec_pc_i;
            retire_rd_o    <= dec_rd_i;
            retire_value_o <= retire_value;
            branch_taken_o <= dec_kind_i == kind_branch && taken;
        end
    end

    a_we_needs_valid: assert property (
        @(posedge clk) disable iff (reset_i) retire_we_o |-> retire_valid_o
    );

endmodule

//--- hw/rv32_core_top.sv
module rv32_core_top #(
    parameter int reg_count = 32
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     instr_valid_i,
    input  logic [31:0]              instr_i,
    input  logic [31:0]              pc_i,
    output logic                     illegal_o,
    output logic                     retire_valid_o,
    output logic [31:0]              retire_pc_o,
    output rv32_ctrl_pkg::reg_addr_t retire_rd_o,
    output logic                     retire_we_o,
    output logic [31:0]              retire_value_o,
    output logic                     branch_taken_o
);
    import rv32_ctrl_pkg::*;

    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;

    logic        dec_valid;
    logic [31:0] dec_pc;
    reg_addr_t   dec_rs1_addr;
    logic [31:0] dec_rs1_value;
    reg_addr_t   dec_rs2_addr;
    logic [31:0] dec_rs2_value;
    logic [31:0] dec_imm;
    reg_addr_t   dec_rd;
    logic [2:0]  dec_funct3;
    alu_op_e     dec_alu_op;
    src_a_e      dec_src_a;
    src_b_e      dec_src_b;
    kind_e       dec_kind;

    logic        wb_en;
    reg_addr_t   wb_addr;
    logic [31:0] wb_value;

    rv32_decode #(
        .reg_count(reg_count)
    ) i_decode (
        .clk             (clk),
        .reset_i         (reset_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .rs1_value_i     (rs1_value),
        .rs2_value_i     (rs2_value),
        .rs1_addr_o      (rs1_addr),
        .rs2_addr_o      (rs2_addr),
        .illegal_o       (illegal_o),
        .dec_valid_o     (dec_valid),
        .dec_pc_o        (dec_pc),
        .dec_rs1_addr_o  (dec_rs1_addr),
        .dec_rs1_value_o (dec_rs1_value),
        .dec_rs2_addr_o  (dec_rs2_addr),
        .dec_rs2_value_o (dec_rs2_value),
        .dec_imm_o       (dec_imm),
        .dec_rd_o        (dec_rd),
        .dec_funct3_o    (dec_funct3),
        .dec_alu_op_o    (dec_alu_op),
        .dec_src_a_o     (dec_src_a),
        .dec_src_b_o     (dec_src_b),
        .dec_kind_o      (dec_kind)
    );

    rv32_regs #(
        .reg_count(reg_count)
    ) i_regs (
        .clk         (clk),
        .reset_i     (reset_i),
        .rs1_addr_i  (rs1_addr),
        .rs2_addr_i  (rs2_addr),
        .wb_en_i     (wb_en),
        .wb_addr_i   (wb_addr),
        .wb_value_i  (wb_value),
        .rs1_value_o (rs1_value),
        .rs2_value_o (rs2_value)
    );

    rv32_execute i_execute (
        .clk             (clk),
        .reset_i         (reset_i),
        .dec_valid_i     (dec_valid),
        .dec_pc_i        (dec_pc),
        .dec_rs1_addr_i  (dec_rs1_addr),
        .dec_rs1_value_i (dec_rs1_value),
        .dec_rs2_addr_i  (dec_rs2_addr),
        .dec_rs2_value_i (dec_rs2_value),
        .dec_imm_i       (dec_imm),
        .dec_rd_i        (dec_rd),
        .dec_funct3_i    (dec_funct3),
        .dec_alu_op_i    (dec_alu_op),
        .dec_src_a_i     (dec_src_a),
        .dec_src_b_i     (dec_src_b),
        .dec_kind_i      (dec_kind),
        .wb_en_o         (wb_en),
        .wb_addr_o       (wb_addr),
        .wb_value_o      (wb_value),
        .retire_valid_o  (retire_valid_o),
        .retire_pc_o     (retire_pc_o),
        .retire_rd_o     (retire_rd_o),
        .retire_we_o     (retire_we_o),
        .retire_value_o  (retire_value_o),
        .branch_taken_o  (branch_taken_o)
    );

endmodule

//--- verification/rv32_core_tb.sv
module rv32_core_tb;
    import rv32_isa_pkg::*;

    localparam int max_rows = 32;

    logic        clk;
    logic        reset_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        illegal_o;
    logic        retire_valid_o;
    logic [31:0] retire_pc_o;
    logic [4:0]  retire_rd_o;
    logic        retire_we_o;
    logic [31:0] retire_value_o;
    logic        branch_taken_o;

    // stimulus and expected results, one row per instruction
    string       row_name    [max_rows];
    logic [31:0] row_instr   [max_rows];
    logic [31:0] row_pc      [max_rows];
    logic        row_illegal [max_rows];
    logic [4:0]  row_rd      [max_rows];
    logic        row_we      [max_rows];
    logic [31:0] row_value   [max_rows];
    logic        row_taken   [max_rows];
    int          num_rows = 0;

    int          expect_q [$]; // row indices of instructions in flight
    logic [31:0] lfsr_state = 32'hf37b_02d3;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    rv32_core_top #(
        .reg_count(32)
    ) i_dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .illegal_o      (illegal_o),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_we_o    (retire_we_o),
        .retire_value_o (retire_value_o),
        .branch_taken_o (branch_taken_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // RV32I instruction formats
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opcode_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcode_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcode_jal};
    endfunction

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic pick_gap(output int gap);
        logic [2:0] bits;
        bits = '0;
        for (int i = 0; i < 3; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[1:0], lfsr_state[0]};
        end
        gap = (bits > 3'd3) ? 3 : int'(bits);
    endtask

    task automatic add_row(input string name, input logic [31:0] instr, input logic [31:0] pc,
                           input logic illegal, input logic [4:0] rd, input logic we,
                           input logic [31:0] value, input logic taken);
        row_name[num_rows]    = name;
        row_instr[num_rows]   = instr;
        row_pc[num_rows]      = pc;
        row_illegal[num_rows] = illegal;
        row_rd[num_rows]      = rd;
        row_we[num_rows]      = we;
        row_value[num_rows]   = value;
        row_taken[num_rows]   = taken;
        num_rows++;
    endtask

    task automatic fill_table();
        add_row("lui", u_type(20'h12345, 5'd1, opcode_lui), 32'h100,
                1'b0, 5'd1, 1'b1, 32'h1234_5000, 1'b0);
        add_row("addi_neg", i_type(32'hffff_fffb, 5'd0, funct3_add_sub, 5'd2, opcode_op_imm),
                32'h104, 1'b0, 5'd2, 1'b1, 32'hffff_fffb, 1'b0);
        add_row("slti", i_type(32'hffff_fffc, 5'd2, funct3_slt, 5'd3, opcode_op_imm), 32'h108,
                1'b0, 5'd3, 1'b1, 32'h1, 1'b0); // -5 < -4
        add_row("xori", i_type(32'h0f0, 5'd1, funct3_xor, 5'd4, opcode_op_imm), 32'h10c,
                1'b0, 5'd4, 1'b1, 32'h1234_50f0, 1'b0);
        add_row("srai", i_type(32'h401, 5'd2, funct3_srl_sra, 5'd5, opcode_op_imm), 32'h110,
                1'b0, 5'd5, 1'b1, 32'hffff_fffd, 1'b0);
        add_row("sub", r_type(funct7_alt, 5'd2, 5'd1, funct3_add_sub, 5'd6, opcode_op), 32'h114,
                1'b0, 5'd6, 1'b1, 32'h1234_5005, 1'b0);
        add_row("slt", r_type(funct7_zero, 5'd1, 5'd2, funct3_slt, 5'd7, opcode_op), 32'h118,
                1'b0, 5'd7, 1'b1, 32'h1, 1'b0);
        add_row("sltu", r_type(funct7_zero, 5'd1, 5'd2, funct3_sltu, 5'd8, opcode_op), 32'h11c,
                1'b0, 5'd8, 1'b1, 32'h0, 1'b0); // 0xfffffffb is the larger unsigned
        add_row("and", r_type(funct7_zero, 5'd4, 5'd1, funct3_and, 5'd9, opcode_op), 32'h120,
                1'b0, 5'd9, 1'b1, 32'h1234_5000, 1'b0);

        // dependent chain through x10, x11 and x12
        add_row("chain_addi0", i_type(32'd7, 5'd0, funct3_add_sub, 5'd10, opcode_op_imm),
                32'h124, 1'b0, 5'd10, 1'b1, 32'd7, 1'b0);
        add_row("chain_addi1", i_type(32'd3, 5'd10, funct3_add_sub, 5'd10, opcode_op_imm),
                32'h128, 1'b0, 5'd10, 1'b1, 32'd10, 1'b0);
        add_row("chain_add", r_type(funct7_zero, 5'd10, 5'd10, funct3_add_sub, 5'd11, opcode_op),
                32'h12c, 1'b0, 5'd11, 1'b1, 32'd20, 1'b0);
        add_row("chain_sub", r_type(funct7_alt, 5'd10, 5'd11, funct3_add_sub, 5'd12, opcode_op),
                32'h130, 1'b0, 5'd12, 1'b1, 32'd10, 1'b0);

        add_row("jal", j_type(32'd16, 5'd13), 32'h134, 1'b0, 5'd13, 1'b1, 32'h138, 1'b0);
        add_row("jalr", i_type(32'd8, 5'd1, funct3_jalr, 5'd14, opcode_jalr), 32'h138,
                1'b0, 5'd14, 1'b1, 32'h13c, 1'b0);
        add_row("beq_taken", b_type(32'd32, 5'd12, 5'd10, funct3_beq), 32'h13c,
                1'b0, 5'd0, 1'b0, 32'h15c, 1'b1);
        add_row("blt_not_taken", b_type(32'hffff_fff8, 5'd2, 5'd1, funct3_blt), 32'h140,
                1'b0, 5'd0, 1'b0, 32'h138, 1'b0);
        add_row("sw", s_type(32'd12, 5'd1, 5'd2, funct3_sw), 32'h144,
                1'b0, 5'd0, 1'b0, 32'h7, 1'b0);
        add_row("lw", i_type(32'hffff_fffc, 5'd1, funct3_lw, 5'd15, opcode_load), 32'h148,
                1'b0, 5'd0, 1'b0, 32'h1234_4ffc, 1'b0);

        add_row("addi_x0", i_type(32'd5, 5'd1, funct3_add_sub, 5'd0, opcode_op_imm), 32'h14c,
                1'b0, 5'd0, 1'b0, 32'h1234_5005, 1'b0);
        add_row("read_x0", r_type(funct7_zero, 5'd10, 5'd0, funct3_add_sub, 5'd16, opcode_op),
                32'h150, 1'b0, 5'd16, 1'b1, 32'd10, 1'b0);

        add_row("bad_opcode", 32'h0000_007f, 32'h154, 1'b1, 5'd0, 1'b0, 32'h0, 1'b0);
        add_row("bad_funct7", r_type(7'b0000001, 5'd2, 5'd1, funct3_add_sub, 5'd19, opcode_op),
                32'h158, 1'b1, 5'd0, 1'b0, 32'h0, 1'b0);

        add_row("auipc", u_type(20'h00001, 5'd17, opcode_auipc), 32'h15c,
                1'b0, 5'd17, 1'b1, 32'h115c, 1'b0);
        add_row("add_after_illegal",
                r_type(funct7_zero, 5'd11, 5'd16, funct3_add_sub, 5'd18, opcode_op), 32'h160,
                1'b0, 5'd18, 1'b1, 32'd30, 1'b0);
    endtask

    task automatic expect_equal(input string name, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %h, actual %h", name, field, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic drive_row(input int r);
        instr_valid_i = 1'b1;
        instr_i       = row_instr[r];
        pc_i          = row_pc[r];
        expect_q.push_back(r);
    endtask

    task automatic check_retire();
        int r;
        if (expect_q.size() == 0) begin
            $display("an instruction retired while none was outstanding");
            $display("TEST FAILED");
            $fatal(1, "unexpected retire");
        end else begin
            r = expect_q.pop_front();
            expect_equal(row_name[r], "illegal", 32'(row_illegal[r]), 32'h0);
            expect_equal(row_name[r], "pc", row_pc[r], retire_pc_o);
            expect_equal(row_name[r], "we", 32'(row_we[r]), 32'(retire_we_o));
            if (row_we[r]) begin
                expect_equal(row_name[r], "rd", 32'(row_rd[r]), 32'(retire_rd_o));
            end
            expect_equal(row_name[r], "value", row_value[r], retire_value_o);
            expect_equal(row_name[r], "taken", 32'(row_taken[r]), 32'(branch_taken_o));
        end
    endtask

    task automatic check_illegal();
        int r;
        if (expect_q.size() == 0) begin
            $display("illegal_o pulsed while no instruction was outstanding");
            $display("TEST FAILED");
            $fatal(1, "unexpected illegal pulse");
        end else begin
            r = expect_q.pop_front();
            expect_equal(row_name[r], "illegal", 32'(row_illegal[r]), 32'h1);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!reset_i) begin
            if (retire_valid_o) begin
                check_retire(); // a retire in the same cycle is always the older instruction
            end
            if (illegal_o) begin
                check_illegal();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int gap;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        fill_table();
        cycle_limit = num_rows * 6 + 20;

        repeat (4) @(posedge clk);
        #1;
        reset_i = 1'b0;

        // the second pass sends every row back to back, so each dependency
        // on the row just before it is served by the forward path
        for (int pass = 0; pass < 2; pass++) begin
            for (int r = 0; r < num_rows; r++) begin
                drive_row(r);
                @(posedge clk);
                #1;
                instr_valid_i = 1'b0;
                if (pass == 0) begin
                    pick_gap(gap); // gap 0 sends the next row back to back
                end else begin
                    gap = 0;
                end
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
        end

        repeat (4) @(posedge clk);
        #1;
        if (expect_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("%0d instructions neither retired nor flagged illegal", expect_q.size());
            $display("TEST FAILED");
            $fatal(1, "instructions left outstanding");
        end
    end

endmodule

//--- sources.f
hw/rv32_isa_pkg.sv
hw/rv32_ctrl_pkg.sv
hw/rv32_decode.sv
hw/rv32_regs.sv
hw/rv32_execute.sv
hw/rv32_core_top.sv
verification/rv32_core_tb.sv

//--- Bender.yml
package:
  name: rv32_core

sources:
  - files:
      - hw/rv32_isa_pkg.sv
      - hw/rv32_ctrl_pkg.sv
      - hw/rv32_decode.sv
      - hw/rv32_regs.sv
      - hw/rv32_execute.sv
      - hw/rv32_core_top.sv
  - target: test
    files:
      - verification/rv32_core_tb.sv
